//--- verilog/fpu_pkg.sv
/*
  fpu coprocessor shared definitions
  field widths, float fields, bus map, operation codes and control states
*/
`default_nettype none

package fpu_pkg;

  // packed single precision layout
  localparam int float_w  = 32;
  localparam int exp_w    = 8;
  localparam int frac_w   = 23;
  // fraction plus hidden bit
  localparam int mant_w   = 24;
  // mantissa plus carry bit plus sign bit
  localparam int guard_w  = 26;
  // full width of the mantissa product
  localparam int prod_w   = 48;
  localparam int exp_bias = 127;

  typedef logic [float_w-1:0]         float_t;
  typedef logic [exp_w-1:0]           exp_t;
  typedef logic [mant_w-1:0]          mant_t;
  // two's complement working mantissa for add and subtract
  typedef logic signed [guard_w-1:0]  guard_mant_t;
  typedef logic [7:0]                 byte_t;
  typedef logic [3:0]                 addr_t;

  // 1.0 as reset value of both operands
  localparam float_t float_one = 32'h3f80_0000;

  // register map
  // operands are stored least significant byte first
  localparam addr_t addr_a0    = 4'h0;
  localparam addr_t addr_b0    = 4'h4;
  localparam addr_t addr_op    = 4'h8;
  // start is write only
  localparam addr_t addr_start = 4'h9;
  // result shares address 9 on the read side
  localparam addr_t addr_res0  = 4'h9;

  typedef enum logic [3:0] {
    op_add = 4'd0,
    op_sub = 4'd1,
    op_mul = 4'd2
  } fpu_op_e;

  // command sequencing
  typedef enum logic [1:0] {
    st_idle,
    st_exec,
    st_wait_ack
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- verilog/fpu_operand_if.sv
/*
  fpu operand bundle
  operands and operation from the register file, results back from both units
*/
`timescale 1ns/10ps
`default_nettype none

interface fpu_operand_if;
  import fpu_pkg::*;

  float_t  a;
  float_t  b;
  fpu_op_e op;
  // combinational unit outputs
  float_t  addsub_res;
  float_t  mul_res;

  // register file owns the operands and picks one result
  modport regs (output a, b, op, input addsub_res, mul_res);

  // add/subtract needs op to choose the direction
  modport addsub (input a, b, op, output addsub_res);

  modport mul (input a, b, output mul_res);

endinterface

`default_nettype wire

//--- verilog/fpu_regs.sv
/*
  fpu register file
  byte bus decode, operand/op/result registers, start request and readback
*/
`timescale 1ns/10ps
`default_nettype none

module fpu_regs (
  input  logic            clk,
  input  logic            arst,
  input  fpu_pkg::byte_t  databus_in,
  output fpu_pkg::byte_t  databus_out,
  input  fpu_pkg::addr_t  addr,
  input  logic            cs,
  input  logic            rd,
  input  logic            wr,
  input  logic            busy,
  input  logic            capture,
  output logic            start_req,
  fpu_operand_if.regs     ops
);
  import fpu_pkg::*;

  float_t  a_q;
  float_t  b_q;
  fpu_op_e op_q;
  float_t  res_q;
  float_t  res_sel;
  // byte offsets inside each 32-bit field
  addr_t   a_off;
  addr_t   b_off;
  addr_t   r_off;
  logic    bus_wr;
  logic    bus_rd;

  assign bus_wr = !cs && !wr;
  assign bus_rd = !cs && !rd;

  assign a_off = addr - addr_a0;
  assign b_off = addr - addr_b0;
  assign r_off = addr - addr_res0;

  assign ops.a  = a_q;
  assign ops.b  = b_q;
  assign ops.op = op_q;

  // multiply result only for op_mul
  assign res_sel = (op_q == op_mul) ? ops.mul_res : ops.addsub_res;

  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      a_q       <= float_one;
      b_q       <= float_one;
      op_q      <= op_add;
      res_q     <= '0;
      start_req <= 1'b0;
    end else begin
      if (bus_wr) begin
        case (addr)
          addr_a0, addr_a0 + 4'd1, addr_a0 + 4'd2, addr_a0 + 4'd3: begin
            a_q[{a_off[1:0], 3'b000} +: 8] <= databus_in;
          end
          addr_b0, addr_b0 + 4'd1, addr_b0 + 4'd2, addr_b0 + 4'd3: begin
            b_q[{b_off[1:0], 3'b000} +: 8] <= databus_in;
          end
          addr_op: begin
            op_q <= fpu_op_e'(databus_in[3:0]);
          end
          addr_start: begin
            // a start while a command runs is dropped
            if (!busy) begin
              start_req <= 1'b1;
            end
          end
          default: begin
          end
        endcase
      end
      // result capture wins over a bus write to A in the same cycle
      if (capture) begin
        res_q     <= res_sel;
        a_q       <= res_sel;
        start_req <= 1'b0;
      end
    end
  end

  // readback is combinational, 0 when not addressed
  always_comb begin
    databus_out = '0;
    if (bus_rd) begin
      case (addr)
        addr_a0, addr_a0 + 4'd1, addr_a0 + 4'd2, addr_a0 + 4'd3: begin
          databus_out = a_q[{a_off[1:0], 3'b000} +: 8];
        end
        addr_b0, addr_b0 + 4'd1, addr_b0 + 4'd2, addr_b0 + 4'd3: begin
          databus_out = b_q[{b_off[1:0], 3'b000} +: 8];
        end
        addr_op: begin
          databus_out = {4'b0000, op_q};
        end
        addr_res0, addr_res0 + 4'd1, addr_res0 + 4'd2, addr_res0 + 4'd3: begin
          databus_out = res_q[{r_off[1:0], 3'b000} +: 8];
        end
        default: begin
          databus_out = '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/fpu_ctrl.sv
/*
  fpu command controller
  idle, exec, wait_ack sequencing with registered busy, cmd_end and capture
*/
`timescale 1ns/10ps
`default_nettype none

module fpu_ctrl (
  input  logic clk,
  input  logic arst,
  input  logic start_req,
  input  logic end_ack,
  output logic capture,
  output logic busy,
  output logic cmd_end
);
  import fpu_pkg::*;

  ctrl_state_e state;
  ctrl_state_e state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (start_req) begin
          state_nxt = st_exec;
        end
      end
      // both units are single cycle so exec always lasts one clock
      st_exec: begin
        state_nxt = st_wait_ack;
      end
      // hold here until the host acknowledges
      st_wait_ack: begin
        if (end_ack) begin
          state_nxt = st_idle;
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  // outputs follow the next state so they line up with the state register
  always_ff @(posedge clk, posedge arst) begin
    if (arst) begin
      state   <= st_idle;
      capture <= 1'b0;
      busy    <= 1'b0;
      cmd_end <= 1'b0;
    end else begin
      state   <= state_nxt;
      // high through exec, result loads on the edge into wait_ack
      capture <= (state_nxt == st_exec);
      busy    <= (state_nxt != st_idle);
      cmd_end <= (state_nxt == st_wait_ack);
    end
  end

endmodule

`default_nettype wire

//--- verilog/fpu_addsub.sv
/*
  fpu add/subtract unit
  combinational align, signed add and leading-zero normalize, no rounding
*/
`timescale 1ns/10ps
`default_nettype none

module fpu_addsub (
  fpu_operand_if.addsub ops
);
  import fpu_pkg::*;

  exp_t        a_exp;
  exp_t        b_exp;
  exp_t        exp_big;
  exp_t        res_exp;
  guard_mant_t a_mant;
  guard_mant_t b_mant;
  guard_mant_t a_al;
  guard_mant_t b_al;
  guard_mant_t a_sg;
  guard_mant_t b_sg;
  guard_mant_t sum;
  guard_mant_t mag;
  guard_mant_t norm;
  logic        res_sign;
  logic [4:0]  lz;
  logic [4:0]  shift;

  // position of the first set bit counted from the msb
  function automatic logic [4:0] lzc(guard_mant_t v);
    logic [4:0] n;
    n = 5'(guard_w);
    // last hit going upward is the msb
    for (int i = 0; i < guard_w; i++) begin
      if (v[i]) begin
        n = 5'(guard_w - 1 - i);
      end
    end
    return n;
  endfunction

  assign a_exp = ops.a[float_w-2 -: exp_w];
  assign b_exp = ops.b[float_w-2 -: exp_w];

  // hidden bit only for a nonzero exponent
  assign a_mant = {{(guard_w-mant_w){1'b0}}, |a_exp, ops.a[frac_w-1:0]};
  assign b_mant = {{(guard_w-mant_w){1'b0}}, |b_exp, ops.b[frac_w-1:0]};

  // smaller operand moves right, shifted-out bits are lost
  always_comb begin
    if (a_exp >= b_exp) begin
      exp_big = a_exp;
      a_al    = a_mant;
      b_al    = b_mant >> (a_exp - b_exp);
    end else begin
      exp_big = b_exp;
      a_al    = a_mant >> (b_exp - a_exp);
      b_al    = b_mant;
    end
  end

  assign a_sg = ops.a[float_w-1] ? -a_al : a_al;
  assign b_sg = ops.b[float_w-1] ? -b_al : b_al;

  assign sum      = (ops.op == op_sub) ? a_sg - b_sg : a_sg + b_sg;
  assign res_sign = sum[guard_w-1];
  assign mag      = res_sign ? -sum : sum;

  assign lz    = lzc(mag);
  // bit 23 is the target, the top two bits are carry and sign
  assign shift = lz - 5'd2;

  always_comb begin
    if (mag == '0) begin
      norm    = '0;
      res_exp = '0;
    end else if (mag[mant_w]) begin
      // carry out of the hidden bit
      norm    = mag >> 1;
      res_exp = exp_big + 8'd1;
    end else begin
      norm    = mag << shift;
      res_exp = exp_big - exp_t'(shift);
    end
  end

  assign ops.addsub_res = {res_sign, res_exp, norm[frac_w-1:0]};

endmodule

`default_nettype wire

//--- verilog/fpu_mul.sv
/*
  fpu multiply unit
  combinational mantissa product with round to nearest even
*/
`timescale 1ns/10ps
`default_nettype none

module fpu_mul (
  fpu_operand_if.mul ops
);
  import fpu_pkg::*;

  exp_t              a_exp;
  exp_t              b_exp;
  exp_t              exp_sum;
  exp_t              exp_norm;
  exp_t              res_exp;
  mant_t             a_mant;
  mant_t             b_mant;
  logic [prod_w-1:0] prod;
  logic [prod_w-1:0] prod_norm;
  logic [mant_w:0]   rounded;
  logic              round_bit;
  logic              sticky;
  logic              round_up;
  logic [frac_w-1:0] res_frac;

  assign a_exp  = ops.a[float_w-2 -: exp_w];
  assign b_exp  = ops.b[float_w-2 -: exp_w];
  assign a_mant = {|a_exp, ops.a[frac_w-1:0]};
  assign b_mant = {|b_exp, ops.b[frac_w-1:0]};

  // exponent wraps on overflow
  assign exp_sum = a_exp + b_exp - exp_t'(exp_bias);
  assign prod    = {{mant_w{1'b0}}, a_mant} * {{mant_w{1'b0}}, b_mant};

  // product is 1.x or 1x.x
  assign prod_norm = prod[prod_w-1] ? prod : prod << 1;
  assign exp_norm  = prod[prod_w-1] ? exp_sum + 8'd1 : exp_sum;

  // keep the upper 24 bits
  assign round_bit = prod_norm[prod_w-mant_w-1];
  assign sticky    = |prod_norm[prod_w-mant_w-2:0];
  // tie goes to the even neighbour
  assign round_up  = round_bit && (sticky || prod_norm[prod_w-mant_w]);
  assign rounded   = {1'b0, prod_norm[prod_w-1 -: mant_w]} + {{mant_w{1'b0}}, round_up};

  // rounding carry means 10.0, shift back and bump the exponent
  always_comb begin
    if (rounded[mant_w]) begin
      res_frac = rounded[frac_w:1];
      res_exp  = exp_norm + 8'd1;
    end else begin
      res_frac = rounded[frac_w-1:0];
      res_exp  = exp_norm;
    end
  end

  assign ops.mul_res = {ops.a[float_w-1] ^ ops.b[float_w-1], res_exp, res_frac};

endmodule

`default_nettype wire

//--- verilog/fpu_top.sv
/*
  fpu coprocessor top
  byte bus pins to register file, controller and the add/sub and mul units
*/
`timescale 1ns/10ps
`default_nettype none

module fpu_top (
  input  logic           clk,
  input  logic           arst,
  input  fpu_pkg::byte_t databus_in,
  output fpu_pkg::byte_t databus_out,
  input  fpu_pkg::addr_t addr,
  input  logic           cs,
  input  logic           rd,
  input  logic           wr,
  input  logic           end_ack,
  output logic           cmd_end,
  output logic           busy
);

  // handshake between register file and controller
  logic start_req;
  logic capture;

  fpu_operand_if ops_if ();

  fpu_regs i_regs (
    .clk         (clk),
    .arst        (arst),
    .databus_in  (databus_in),
    .databus_out (databus_out),
    .addr        (addr),
    .cs          (cs),
    .rd          (rd),
    .wr          (wr),
    .busy        (busy),
    .capture     (capture),
    .start_req   (start_req),
    .ops         (ops_if)
  );

  fpu_ctrl i_ctrl (
    .clk       (clk),
    .arst      (arst),
    .start_req (start_req),
    .end_ack   (end_ack),
    .capture   (capture),
    .busy      (busy),
    .cmd_end   (cmd_end)
  );

  // both units evaluate every cycle, the register file picks one
  fpu_addsub i_addsub (
    .ops (ops_if)
  );

  fpu_mul i_mul (
    .ops (ops_if)
  );

endmodule

`default_nettype wire

//--- sim/fpu_assert.sv
/*
  fpu controller assertions
  ordering of busy, capture and cmd_end, bound into every fpu_ctrl
*/
`timescale 1ns/10ps
`default_nettype none

module fpu_ctrl_assert (
  input logic clk,
  input logic arst,
  input logic capture,
  input logic busy,
  input logic cmd_end
);

  // cmd_end only inside an open command
  end_in_busy: assert property (@(posedge clk) disable iff (arst) cmd_end |-> busy)
    else $error("cmd_end high while busy low");

  // result lands on the edge that raises cmd_end
  capture_then_end: assert property (@(posedge clk) disable iff (arst) capture |=> cmd_end)
    else $error("cmd_end missing after capture");

  // single clock strobe
  capture_pulse: assert property (@(posedge clk) disable iff (arst) capture |=> !capture)
    else $error("capture longer than one cycle");

  // busy and capture both come out of the idle to exec step
  busy_with_capture: assert property (@(posedge clk) disable iff (arst) $rose(busy) |-> capture)
    else $error("busy rose without capture");

endmodule

bind fpu_ctrl fpu_ctrl_assert i_ctrl_assert (
  .clk(clk), .arst(arst), .capture(capture), .busy(busy), .cmd_end(cmd_end)
);

`default_nettype wire

//--- sim/tb_fpu.sv
/*
  fpu coprocessor testbench
  reset readback, completion handshake, then a table of add/sub/mul commands
*/
`timescale 1ns/10ps
`default_nettype none

module tb_fpu;
  import fpu_pkg::*;

  // one command, chain reuses the previous result as A
  typedef struct packed {
    float_t     a;
    float_t     b;
    logic [3:0] op;
    float_t     res;
    logic       chain;
  } row_t;

  localparam int done_timeout = 20;

  logic  clk;
  logic  arst;
  byte_t databus_in;
  byte_t databus_out;
  addr_t addr;
  logic  cs;
  logic  rd;
  logic  wr;
  logic  end_ack;
  logic  cmd_end;
  logic  busy;
  row_t  rows[$];
  int    n_tests;
  int    n_fail;

  fpu_top i_dut (
    .clk(clk), .arst(arst), .databus_in(databus_in), .databus_out(databus_out),
    .addr(addr), .cs(cs), .rd(rd), .wr(wr),
    .end_ack(end_ack), .cmd_end(cmd_end), .busy(busy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic add_row(input float_t a, input float_t b, input logic [3:0] op,
                         input float_t res, input logic chain);
    rows.push_back(row_t'{a, b, op, res, chain});
  endtask

  // expected values worked by hand from the truncate and round-to-even rules
  task automatic load_table();
    add_row(32'h3fc00000, 32'h40100000, op_add, 32'h40700000, 1'b0);
    // 3.75 * 2.0, then 7.5 - 0.5
    add_row(32'h0, 32'h40000000, op_mul, 32'h40f00000, 1'b1);
    add_row(32'h0, 32'h3f000000, op_sub, 32'h40e00000, 1'b1);
    add_row(32'h40400000, 32'h40a00000, op_sub, 32'hc0000000, 1'b0);
    add_row(32'h40100000, 32'h40100000, op_sub, 32'h00000000, 1'b0);
    // cancellation, ten place left shift
    add_row(32'h3f802000, 32'h3f800000, op_sub, 32'h3a800000, 1'b0);
    add_row(32'hc0000000, 32'h3f000000, op_add, 32'hbfc00000, 1'b0);
    // carry out, one right shift
    add_row(32'h3fc00000, 32'h3fc00000, op_add, 32'h40400000, 1'b0);
    // lsb of B drops during alignment
    add_row(32'h40000000, 32'h3f800001, op_add, 32'h40400000, 1'b0);
    add_row(32'h3fc00000, 32'h40100000, op_mul, 32'h40580000, 1'b0);
    add_row(32'hc0000000, 32'h40400000, op_mul, 32'hc0c00000, 1'b0);
    // round up, tie up to even, tie down to even
    add_row(32'h3f800001, 32'h3fc00001, op_mul, 32'h3fc00003, 1'b0);
    add_row(32'h3f800001, 32'h3fc00000, op_mul, 32'h3fc00002, 1'b0);
    add_row(32'h3f800003, 32'h3fc00000, op_mul, 32'h3fc00004, 1'b0);
    // rounding carry, result is exactly 2.0
    add_row(32'h3ffffffe, 32'h3f800001, op_mul, 32'h40000000, 1'b0);
  endtask

  task automatic bus_write(input addr_t a, input byte_t d);
    @(negedge clk);
    addr = a;
    databus_in = d;
    cs = 1'b0;
    wr = 1'b0;
    @(negedge clk);
    cs = 1'b1;
    wr = 1'b1;
  endtask

  task automatic write_word(input addr_t base, input float_t w);
    for (int i = 0; i < 4; i++) begin
      bus_write(base + 4'(i), w[8*i +: 8]);
    end
  endtask

  // read mux is combinational, sample mid low phase
  task automatic bus_read(input addr_t base, output float_t w);
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      addr = base + 4'(i);
      cs = 1'b0;
      rd = 1'b0;
      #2;
      w[8*i +: 8] = databus_out;
    end
    @(negedge clk);
    cs = 1'b1;
    rd = 1'b1;
  endtask

  // counts falling edges from the one after the start write
  task automatic wait_cmd_end(output int cycles, output logic done);
    cycles = 0;
    while (!cmd_end && cycles < done_timeout) begin
      @(negedge clk);
      cycles++;
    end
    done = cmd_end;
  endtask

  task automatic ack_cmd(output logic done);
    int n;
    n = 0;
    end_ack = 1'b1;
    while (busy && n < done_timeout) begin
      @(negedge clk);
      n++;
    end
    end_ack = 1'b0;
    done = !busy && !cmd_end;
  endtask

  task automatic finish_test(input string name, input logic ok);
    n_tests++;
    if (!ok) begin
      n_fail++;
    end
    $display("test %s %s", name, ok ? "pass" : "fail");
  endtask

  task automatic check_reset_values();
    float_t w;
    logic   ok;
    ok = 1'b1;
    bus_read(addr_a0, w);
    if (w !== 32'h3f800000) begin
      $display("ERR a got %h exp %h", w, 32'h3f800000);
      ok = 1'b0;
    end
    bus_read(addr_b0, w);
    if (w !== 32'h3f800000) begin
      $display("ERR b got %h exp %h", w, 32'h3f800000);
      ok = 1'b0;
    end
    // op byte, then the low three result bytes
    bus_read(addr_op, w);
    if (w[7:0] !== 8'h00) begin
      $display("ERR op got %h exp %h", w[7:0], 8'h00);
      ok = 1'b0;
    end
    bus_read(addr_res0, w);
    if (w !== 32'h0) begin
      $display("ERR res got %h exp %h", w, 32'h0);
      ok = 1'b0;
    end
    if (busy !== 1'b0 || cmd_end !== 1'b0) begin
      $display("ERR busy/cmd_end got %h/%h exp 0/0", busy, cmd_end);
      ok = 1'b0;
    end
    finish_test("reset readback", ok);
  endtask

  // reset operands give 1.0 + 1.0
  task automatic check_handshake();
    float_t w;
    int     cycles;
    logic   done;
    logic   ok;
    ok = 1'b1;
    bus_write(addr_start, 8'h00);
    wait_cmd_end(cycles, done);
    if (!done) begin
      $display("cmd_end did not rise within %0d cycles", done_timeout);
      ok = 1'b0;
    end
    if (cycles != 2 || busy !== 1'b1) begin
      $display("ERR cmd_end latency got %h exp %h, busy %h", cycles, 2, busy);
      ok = 1'b0;
    end
    // host keeps end_ack low for a while
    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
      if (busy !== 1'b1 || cmd_end !== 1'b1) begin
        $display("ERR busy/cmd_end got %h/%h exp 1/1", busy, cmd_end);
        ok = 1'b0;
      end
    end
    // a start write while busy must not queue a second command
    bus_write(addr_start, 8'h00);
    ack_cmd(done);
    if (!done) begin
      $display("busy or cmd_end still high after end_ack");
      ok = 1'b0;
    end
    repeat (4) @(negedge clk);
    if (busy !== 1'b0) begin
      $display("ERR busy got %h exp %h after start during busy", busy, 1'b0);
      ok = 1'b0;
    end
    bus_read(addr_res0, w);
    if (w !== 32'h40000000) begin
      $display("ERR res got %h exp %h", w, 32'h40000000);
      ok = 1'b0;
    end
    finish_test("handshake", ok);
  endtask

  task automatic run_table();
    float_t w;
    int     cycles;
    logic   done;
    logic   ok;
    for (int i = 0; i < rows.size(); i++) begin
      ok = 1'b1;
      if (!rows[i].chain) begin
        write_word(addr_a0, rows[i].a);
      end
      write_word(addr_b0, rows[i].b);
      bus_write(addr_op, {4'h0, rows[i].op});
      bus_write(addr_start, 8'h00);
      wait_cmd_end(cycles, done);
      if (!done) begin
        $display("cmd_end did not rise within %0d cycles", done_timeout);
        ok = 1'b0;
      end
      ack_cmd(done);
      if (!done) begin
        $display("busy or cmd_end still high after end_ack");
        ok = 1'b0;
      end
      bus_read(addr_res0, w);
      if (w !== rows[i].res) begin
        $display("ERR res got %h exp %h", w, rows[i].res);
        ok = 1'b0;
      end
      // result must also sit in A for the next chained row
      bus_read(addr_a0, w);
      if (w !== rows[i].res) begin
        $display("ERR a got %h exp %h", w, rows[i].res);
        ok = 1'b0;
      end
      finish_test($sformatf("row %0d op %0d", i, rows[i].op), ok);
    end
  endtask

  initial begin
    arst = 1'b1;
    databus_in = '0;
    addr = '0;
    cs = 1'b1;
    rd = 1'b1;
    wr = 1'b1;
    end_ack = 1'b0;
    n_tests = 0;
    n_fail = 0;
    load_table();
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst = 1'b0;
    check_reset_values();
    check_handshake();
    run_table();
    $display("tests %0d failed %0d", n_tests, n_fail);
    if (n_fail == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- fpu_proto.f
verilog/fpu_pkg.sv
verilog/fpu_operand_if.sv
verilog/fpu_regs.sv
verilog/fpu_ctrl.sv
verilog/fpu_addsub.sv
verilog/fpu_mul.sv
verilog/fpu_top.sv
sim/fpu_assert.sv
sim/tb_fpu.sv

//--- run_sim.sh
#!/bin/sh
# build the fpu testbench with verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --assert -j 0 --top-module tb_fpu -Mdir obj_dir -f fpu_proto.f
# the model may exit nonzero on an assertion, the grep below decides
out=$(./obj_dir/Vtb_fpu 2>&1) || true
echo "$out"
if echo "$out" | grep -q "TB PASSED"; then
  exit 0
else
  exit 1
fi
